/* Bender.yml */
package:
  name: nand_command_address_sync

dependencies: {}

sources:
  - hw/nandBusPkg.sv
  - hw/caSequencePkg.sv
  - hw/caTimingSequencer.sv
  - hw/caByteShifter.sv
  - hw/caPinDriver.sv
  - hw/nandCommandAddressSync.sv
  - target: test
    files:
      - bench/caSyncTb.sv

/* flist.f */
hw/nandBusPkg.sv
hw/caSequencePkg.sv
hw/caTimingSequencer.sv
hw/caByteShifter.sv
hw/caPinDriver.sv
hw/nandCommandAddressSync.sv
bench/caSyncTb.sv

/* bench/caSyncTb.sv */
`timescale 1ns/10ps

module caSyncTb
    import nandBusPkg::*;
;

    localparam int NumberOfWays   = 4;
    localparam int holdCycles     = 3;      // each byte stays on dq this long
    localparam int transferTarget = 60;
    localparam int cycleLimit     = 1500;

    typedef struct packed {
        logic                    caSelect;
        logic [NumberOfWays-1:0] targetWay;
        caWord                   word;
        byteCount                lastIndex;
    } caRequest;

    logic                    iSystemClock;
    logic                    iReset;
    logic                    iStart;
    logic [NumberOfWays-1:0] iTargetWay;
    logic                    iCaSelect;
    caWord                   iCaData;
    byteCount                iNumOfData;
    logic                    oReady;
    logic                    oLastStep;
    logic [NumberOfWays-1:0] oChipEnable;
    nandPins                 oPins;

    // reference model state
    caRequest                captured;
    logic                    busy;
    int unsigned             offset;        // cycles since the accepting edge
    logic                    expReady;
    logic                    expLastStep;
    logic [NumberOfWays-1:0] expChipEnable;
    nandPins                 expPins;

    int unsigned latchPulses;
    int unsigned doneCount;
    int unsigned cycleCount;
    int unsigned errorCount;

    nandCommandAddressSync #(
        .NumberOfWays (NumberOfWays)
    ) dut (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iCaSelect    (iCaSelect),
        .iCaData      (iCaData),
        .iNumOfData   (iNumOfData),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oChipEnable  (oChipEnable),
        .oPins        (oPins)
    );

    initial iSystemClock = 1'b0;
    always #5 iSystemClock = ~iSystemClock;

    task automatic reportMismatch(input string checkName, input logic [63:0] expected,
                                  input logic [63:0] actual);
        errorCount = errorCount + 1;
        $display("FAIL %s expected %0h actual %0h", checkName, expected, actual);
    endtask

    task automatic driveRandomRequest();
        caWord word;
        for (int b = 0; b < caWordBytes; b++) begin
            word[b] = nandByte'($urandom);
        end
        iStart     <= ($urandom % 3) == 0;
        iTargetWay <= NumberOfWays'($urandom);
        iCaSelect  <= 1'($urandom);
        iCaData    <= word;
        iNumOfData <= byteCount'($urandom % caWordBytes);
    endtask

    // expected pin levels for the cycle that starts at each edge
    always @(posedge iSystemClock or posedge iReset) begin : referenceModel
        int unsigned nextOffset;
        int unsigned lastOffset;
        int unsigned phase;
        if (iReset) begin
            busy          <= 1'b0;
            offset        <= 0;
            expReady      <= 1'b0;
            expLastStep   <= 1'b0;
            expChipEnable <= '0;
            expPins       <= '0;
        end else if (!busy) begin
            expLastStep   <= 1'b0;
            expChipEnable <= '0;
            expPins       <= '0;
            if (expReady && iStart) begin
                captured.caSelect  <= iCaSelect;
                captured.targetWay <= iTargetWay;
                captured.word      <= iCaData;
                captured.lastIndex <= iNumOfData;
                busy               <= 1'b1;
                offset             <= 0;
                expReady           <= 1'b0;
            end else begin
                expReady <= 1'b1;
            end
        end else begin
            nextOffset = offset + 1;
            lastOffset = holdCycles * captured.lastIndex + 5;   // ready comes back here
            offset <= nextOffset;
            if (nextOffset == lastOffset) begin
                busy          <= 1'b0;
                expReady      <= 1'b1;
                expLastStep   <= 1'b0;
                expChipEnable <= '0;
                expPins       <= '0;
            end else begin
                expChipEnable <= captured.targetWay;                // turnaround included
                expLastStep   <= (nextOffset == lastOffset - 1);
                if (nextOffset < 2) begin
                    expPins <= '0;
                end else begin
                    phase = nextOffset - 2;
                    expPins.dq <= captured.word[caWordBytes - 1 - phase / holdCycles];
                    expPins.commandLatchEnable <= (phase % holdCycles == 0) && captured.caSelect;
                    expPins.addressLatchEnable <= (phase % holdCycles == 0) && !captured.caSelect;
                end
            end
        end
    end

    // latch pulses seen on the pins since the last accept
    always @(posedge iSystemClock or posedge iReset) begin : pulseCounter
        if (iReset) begin
            latchPulses <= 0;
        end else if (expReady && iStart) begin
            latchPulses <= 0;
        end else if (oPins.commandLatchEnable || oPins.addressLatchEnable) begin
            latchPulses <= latchPulses + 1;
        end
    end

    always @(posedge iSystemClock or posedge iReset) begin : completionCounter
        if (iReset) begin
            doneCount <= 0;
        end else if (oLastStep) begin
            doneCount <= doneCount + 1;
        end
    end

    readyCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oReady == expReady)
        else reportMismatch("readyCheck", $sampled(expReady), $sampled(oReady));

    lastStepCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oLastStep == expLastStep)
        else reportMismatch("lastStepCheck", $sampled(expLastStep), $sampled(oLastStep));

    chipEnableCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oChipEnable == expChipEnable)
        else reportMismatch("chipEnableCheck", $sampled(expChipEnable), $sampled(oChipEnable));

    dqCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oPins.dq == expPins.dq)
        else reportMismatch("dqCheck", $sampled(expPins.dq), $sampled(oPins.dq));

    commandLatchCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oPins.commandLatchEnable == expPins.commandLatchEnable)
        else reportMismatch("commandLatchCheck", $sampled(expPins.commandLatchEnable),
                            $sampled(oPins.commandLatchEnable));

    addressLatchCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        oPins.addressLatchEnable == expPins.addressLatchEnable)
        else reportMismatch("addressLatchCheck", $sampled(expPins.addressLatchEnable),
                            $sampled(oPins.addressLatchEnable));

    // one latch pulse per byte by the last step
    pulseCountCheck: assert property (@(posedge iSystemClock) disable iff (iReset)
        expLastStep |-> latchPulses == captured.lastIndex + 1)
        else reportMismatch("pulseCountCheck", $sampled(captured.lastIndex) + 1,
                            $sampled(latchPulses));

    always @(posedge iSystemClock) begin : watchdog
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            errorCount = errorCount + 1;
            $display("timeout: transfers did not complete");
            $display("errors: %0d, transfers: %0d", errorCount, doneCount);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin : stimulus
        errorCount = 0;
        cycleCount = 0;
        void'($urandom(32'hf57c6c90));
        iReset     = 1'b1;
        iStart     = 1'b0;
        iTargetWay = '0;
        iCaSelect  = 1'b0;
        iCaData    = '0;
        iNumOfData = '0;
        repeat (4) @(posedge iSystemClock);
        iReset <= 1'b0;
        repeat (3) @(posedge iSystemClock);     // quiet pins while ready
        while (doneCount < transferTarget) begin
            @(posedge iSystemClock);
            driveRandomRequest();               // also hits the busy cycles
        end
        iStart <= 1'b0;
        repeat (4) @(posedge iSystemClock);
        $display("errors: %0d, transfers: %0d", errorCount, doneCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hw/nandCommandAddressSync.sv */
`timescale 1ns/10ps

module nandCommandAddressSync
    import nandBusPkg::*, caSequencePkg::*;
#(
    parameter int NumberOfWays = 4
)
(
    input  logic                    iSystemClock,
    input  logic                    iReset,
    input  logic                    iStart,
    input  logic [NumberOfWays-1:0] iTargetWay,
    input  logic                    iCaSelect,
    input  caWord                   iCaData,
    input  byteCount                iNumOfData,
    output logic                    oReady,
    output logic                    oLastStep,
    output logic [NumberOfWays-1:0] oChipEnable,
    output nandPins                 oPins
);

    caStep                   step;
    logic                    byteDone;
    nandByte                 currentByte;
    logic                    caSelect;
    logic [NumberOfWays-1:0] targetWay;

    caTimingSequencer sequencer (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iNumOfData   (iNumOfData),
        .oReady       (oReady),
        .oStep        (step),
        .oByteDone    (byteDone)
    );

    caByteShifter #(
        .NumberOfWays (NumberOfWays)
    ) shifter (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iReady       (oReady),
        .iByteDone    (byteDone),
        .iCaSelect    (iCaSelect),
        .iTargetWay   (iTargetWay),
        .iCaData      (iCaData),
        .oCurrentByte (currentByte),
        .oCaSelect    (caSelect),
        .oTargetWay   (targetWay)
    );

    // one cycle behind the sequencer and shifter
    caPinDriver #(
        .NumberOfWays (NumberOfWays)
    ) pinDriver (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStep        (step),
        .iCurrentByte (currentByte),
        .iCaSelect    (caSelect),
        .iTargetWay   (targetWay),
        .oPins        (oPins),
        .oChipEnable  (oChipEnable),
        .oLastStep    (oLastStep)
    );

endmodule

/* hw/caPinDriver.sv */
`timescale 1ns/10ps

module caPinDriver
    import nandBusPkg::*, caSequencePkg::*;
#(
    parameter int NumberOfWays = 4
)
(
    input  logic                    iSystemClock,
    input  logic                    iReset,
    input  caStep                   iStep,
    input  nandByte                 iCurrentByte,
    input  logic                    iCaSelect,
    input  logic [NumberOfWays-1:0] iTargetWay,
    output nandPins                 oPins,
    output logic [NumberOfWays-1:0] oChipEnable,
    output logic                    oLastStep
);

    logic latchPulse;

    // latch enable only in the first cycle of a byte
    assign latchPulse = iStep.sending && iStep.firstCycle;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oPins       <= '0;
            oChipEnable <= '0;
            oLastStep   <= 1'b0;
        end else begin
            oPins.dq                 <= iStep.sending ? iCurrentByte : '0;
            oPins.commandLatchEnable <= latchPulse && iCaSelect;
            oPins.addressLatchEnable <= latchPulse && !iCaSelect;
            oChipEnable              <= iStep.active ? iTargetWay : '0;    // turnaround too
            oLastStep                <= iStep.lastStep;
        end
    end

    // each latch enable pulse lasts one cycle
    latchSingleCycle: assert property (@(posedge iSystemClock) disable iff (iReset)
        (oPins.addressLatchEnable || oPins.commandLatchEnable) |=>
            !(oPins.addressLatchEnable || oPins.commandLatchEnable));

endmodule

/* hw/caByteShifter.sv */
`timescale 1ns/10ps

module caByteShifter
    import nandBusPkg::*;
#(
    parameter int NumberOfWays = 4
)
(
    input  logic                    iSystemClock,
    input  logic                    iReset,
    input  logic                    iStart,
    input  logic                    iReady,
    input  logic                    iByteDone,
    input  logic                    iCaSelect,
    input  logic [NumberOfWays-1:0] iTargetWay,
    input  caWord                   iCaData,
    output nandByte                 oCurrentByte,
    output logic                    oCaSelect,
    output logic [NumberOfWays-1:0] oTargetWay
);

    caWord shiftWord;
    logic  load;

    assign load = iStart && iReady;     // same edge the sequencer accepts

    always_ff @(posedge iSystemClock) begin
        if (load) begin
            shiftWord  <= iCaData;
            oCaSelect  <= iCaSelect;
            oTargetWay <= iTargetWay;
        end else if (iByteDone) begin
            // move the next byte into the top slot
            shiftWord <= {shiftWord[caWordBytes-2:0], nandByte'(0)};
        end
    end

    assign oCurrentByte = shiftWord[caWordBytes-1];

    // byteDone only comes while the sequencer is away from ready
    loadNotShift: assert property (@(posedge iSystemClock) disable iff (iReset)
        !(load && iByteDone));

endmodule

/* hw/caTimingSequencer.sv */
`timescale 1ns/10ps

module caTimingSequencer
    import nandBusPkg::*, caSequencePkg::*;
(
    input  logic     iSystemClock,
    input  logic     iReset,
    input  logic     iStart,
    input  byteCount iNumOfData,
    output logic     oReady,
    output caStep    oStep,
    output logic     oByteDone
);

    caState                state;
    caState                nextState;
    logic [timerWidth-1:0] timer;
    byteCount              byteIndex;
    byteCount              lastIndex;
    logic                  accept;
    logic                  timerDone;
    logic                  lastStep;

    assign accept    = iStart && oReady;
    assign timerDone = (state == sendByte) && (timer == timerWidth'(cyclesPerByte - 1));
    assign lastStep  = timerDone && (byteIndex == lastIndex);

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                nextState = ready;
            end
            ready: begin
                if (accept) begin
                    nextState = turnaround;
                end
            end
            turnaround: begin
                nextState = sendByte;
            end
            sendByte: begin
                // idle holds ready low while the pins drain
                if (lastStep) begin
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state     <= idle;
            timer     <= '0;
            byteIndex <= '0;
            lastIndex <= '0;
        end else begin
            state <= nextState;
            if (accept) begin
                lastIndex <= iNumOfData;
            end
            if (state != sendByte || timerDone) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end
            if (state != sendByte || lastStep) begin
                byteIndex <= '0;
            end else if (timerDone) begin
                byteIndex <= byteIndex + 1'b1;  // next byte
            end
        end
    end

    assign oReady    = (state == ready);
    assign oByteDone = timerDone;

    assign oStep.active     = (state == turnaround) || (state == sendByte);
    assign oStep.sending    = (state == sendByte);
    assign oStep.firstCycle = (state == sendByte) && (timer == '0);
    assign oStep.lastStep   = lastStep;
    assign oStep.byteIndex  = byteIndex;

    // catches an illegal iNumOfData
    byteIndexInRange: assert property (@(posedge iSystemClock) disable iff (iReset)
        byteIndex <= byteCount'(caWordBytes - 1));

endmodule

/* hw/caSequencePkg.sv */
package caSequencePkg;

    import nandBusPkg::*;

    localparam int unsigned cyclesPerByte = 3;     // hold time of each byte
    localparam int unsigned timerWidth = $clog2(cyclesPerByte);

    typedef enum logic [1:0] {
        idle,           // after reset and after each transfer
        ready,
        turnaround,     // tCAD
        sendByte
    } caState;

    // pacing info handed to the pin driver
    typedef struct packed {
        logic     active;       // turnaround included
        logic     sending;
        logic     firstCycle;
        logic     lastStep;
        byteCount byteIndex;
    } caStep;

endpackage

/* hw/nandBusPkg.sv */
package nandBusPkg;

    // one byte on the DQ bus
    typedef logic [7:0] nandByte;

    localparam int unsigned caWordBytes = 5;

    // byte caWordBytes-1 goes out first
    typedef nandByte [caWordBytes-1:0] caWord;

    // index of a byte inside the word
    // only 0 to caWordBytes-1 are legal
    typedef logic [2:0] byteCount;

    // single copy of each NAND pin lane
    typedef struct packed {
        nandByte dq;
        logic    addressLatchEnable;
        logic    commandLatchEnable;
    } nandPins;

endpackage
